//--- sources.f
verilog/fftPkg.sv
verilog/fftCtrlIf.sv
verilog/sampleFifo.sv
verilog/butterflyUnit.sv
verilog/fftCtrl.sv
verilog/fftCore.sv
verilog/wbRegs.sv
verilog/fftAccel.sv
verif/fftAccelTb.sv

//--- verif/fftAccelTb.sv
`timescale 1ns/1ns
`default_nettype none

module fftAccelTb;
    import fftPkg::*;

    localparam int numRows    = 8;
    localparam int ackTimeout = 50;              // Cycles per bus transfer
    localparam int pollLimit  = 200;             // Status reads per transform
    localparam int randomSeed = 95164;

    localparam logic [31:0] startFWord = 32'(1) << ctrlStartF;
    localparam logic [31:0] startIWord = 32'(1) << ctrlStartI;
    localparam logic [31:0] loadWord   = 32'(1) << ctrlLoad;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] datW;
    logic [31:0] datR;
    logic        ack;

    // Stimulus table, one transform per row
    bit rowInverse [numRows];
    int rowRe      [numRows][fftPoints];
    int rowIm      [numRows][fftPoints];

    // Reference model working set, natural order after a run
    int workRe [fftPoints];
    int workIm [fftPoints];
    int twRe   [4] = '{16384, 11585, 0, -11585};
    int twIm   [4] = '{0, -11585, -16384, -11585};

    fftAccel dut (
        .clk  (clk),
        .rst  (rst),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .datW (datW),
        .datR (datR),
        .ack  (ack)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            stopRun($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone host
    ////////////////////////////////////////////////////////////////////////////
    task automatic busTransfer(input bit write, input logic [2:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        datW   = wdata;
        waited = 0;
        @(negedge clk);
        while (!ack && waited < ackTimeout) begin   // Data-in writes stall on a full FIFO
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            stopRun($sformatf("No bus ack from register %0d within %0d cycles", addr, ackTimeout));
        end
        rdata = datR;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wbWrite(input logic [2:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        busTransfer(1'b1, addr, data, unused);
    endtask

    task automatic wbRead(input logic [2:0] addr, output logic [31:0] data);
        busTransfer(1'b0, addr, 32'h0, data);
    endtask

    function automatic logic [31:0] statusWord(input bit busy, input bit done,
                                               input bit inEmpty, input bit outEmpty);
        logic [31:0] w;
        w                 = '0;
        w[statusBusy]     = busy;
        w[statusDone]     = done;
        w[statusInEmpty]  = inEmpty;
        w[statusOutEmpty] = outEmpty;
        return w;
    endfunction

    task automatic checkStatus(input logic [31:0] expected, input string label);
        logic [31:0] value;
        wbRead(REG_STATUS, value);
        checkValue($sformatf("status (%s)", label), value, expected);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic int wrap16(input longint v);
        logic signed [15:0] t;
        t = v[15:0];
        return int'(t);
    endfunction

    function automatic int bitReverse(input int k);
        return {k[0], k[1], k[2]};
    endfunction

    function automatic logic [31:0] packSample(input int re, input int im);
        return {re[15:0], im[15:0]};                // re in upper half
    endfunction

    // Decimation in time, bit-reversed input, truncating Q1.14 products
    task automatic modelTransform(input int row, input bit inverse);
        int     half;
        int     top;
        int     bot;
        int     tw;
        longint wr;
        longint wi;
        longint tr;
        longint ti;
        longint xr;
        longint xi;
        longint yr;
        longint yi;
        for (int k = 0; k < fftPoints; k++) begin
            workRe[bitReverse(k)] = rowRe[row][k];
            workIm[bitReverse(k)] = rowIm[row][k];
        end
        for (int s = 0; s < 3; s++) begin
            half = 1 << s;
            for (int g = 0; g < fftPoints; g += 2 * half) begin
                for (int p = 0; p < half; p++) begin
                    top = g + p;
                    bot = top + half;
                    tw  = p << (2 - s);
                    wr  = twRe[tw];
                    wi  = inverse ? -twIm[tw] : twIm[tw];    // Conjugate twiddle
                    tr  = (workRe[bot] * wr - workIm[bot] * wi) >>> 14;
                    ti  = (workRe[bot] * wi + workIm[bot] * wr) >>> 14;
                    xr  = workRe[top] + tr;
                    xi  = workIm[top] + ti;
                    yr  = workRe[top] - tr;
                    yi  = workIm[top] - ti;
                    if (inverse) begin
                        xr = xr >>> 1;
                        xi = xi >>> 1;
                        yr = yr >>> 1;
                        yi = yi >>> 1;
                    end
                    workRe[top] = wrap16(xr);
                    workIm[top] = wrap16(xi);
                    workRe[bot] = wrap16(yr);
                    workIm[bot] = wrap16(yi);
                end
            end
        end
    endtask

    function automatic int randomPart();
        return int'($urandom % 32'd4095) - 2047;    // Keeps every stage in range
    endfunction

    task automatic fillTable();
        for (int r = 0; r < numRows; r++) begin
            rowInverse[r] = (r == 3 || r == 5 || r == 6);
            for (int k = 0; k < fftPoints; k++) begin
                case (r)
                    0: begin
                        rowRe[r][k] = (k == 0) ? 1024 : 0;
                        rowIm[r][k] = 0;
                    end
                    1: begin
                        rowRe[r][k] = 100;
                        rowIm[r][k] = -60;
                    end
                    2: begin
                        rowRe[r][k] = (k % 2) ? -500 : 500;
                        rowIm[r][k] = 0;
                    end
                    3: begin
                        rowRe[r][k] = (k == 0) ? 800 : 0;
                        rowIm[r][k] = 0;
                    end
                    default: begin
                        rowRe[r][k] = randomPart();
                        rowIm[r][k] = randomPart();
                    end
                endcase
            end
        end
        // Row 6 takes the spectrum of row 4 back through the inverse
        modelTransform(4, 1'b0);
        for (int k = 0; k < fftPoints; k++) begin
            rowRe[6][k] = workRe[k];
            rowIm[6][k] = workIm[k];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One full host sequence
    ////////////////////////////////////////////////////////////////////////////
    task automatic runTransform(input int row, input logic [31:0] startWord,
                                input bit loadFirst);
        logic [31:0] value;
        bit          inverse;
        int          polls;
        string       tag;
        tag     = $sformatf("row %0d", row);
        inverse = !startWord[ctrlStartF];           // Forward request takes priority
        modelTransform(row, inverse);

        wbWrite(REG_CTRL, startWord);
        checkStatus(statusWord(1, 0, 1, 1), $sformatf("%s after start", tag));
        if (loadFirst) begin
            wbWrite(REG_CTRL, loadWord);            // Core stalls until samples arrive
        end
        for (int k = 0; k < fftPoints; k++) begin
            wbWrite(REG_DATA_IN, packSample(rowRe[row][k], rowIm[row][k]));
        end
        if (!loadFirst) begin
            // A full input FIFO must not start anything by itself
            repeat (3) checkStatus(statusWord(1, 0, 0, 1), $sformatf("%s before load", tag));
            wbWrite(REG_CTRL, loadWord);
        end

        polls = 0;
        value = '0;
        while (!value[statusDone] && polls < pollLimit) begin
            wbRead(REG_STATUS, value);
            polls++;
        end
        if (!value[statusDone]) begin
            stopRun($sformatf("Transform of %s never reported done", tag));
        end
        checkValue($sformatf("status (%s at done)", tag), value, statusWord(1, 1, 1, 0));

        for (int k = 0; k < fftPoints; k++) begin
            wbRead(REG_DATA_OUT, value);
            checkValue($sformatf("datR (%s bin %0d)", tag, k), value,
                       packSample(workRe[k], workIm[k]));
        end
        checkStatus(statusWord(1, 1, 1, 1), $sformatf("%s after drain", tag));
        wbRead(REG_DATA_OUT, value);
        checkValue($sformatf("datR (%s empty read)", tag), value, 32'h0);

        wbWrite(REG_ACK, 32'h0);
        checkStatus(statusWord(0, 1, 1, 1), $sformatf("%s after ack", tag));
    endtask

    initial begin
        void'($urandom(randomSeed));
        clk  = 1'b0;
        rst  = 1'b1;
        cyc  = 1'b0;
        stb  = 1'b0;
        we   = 1'b0;
        adr  = '0;
        datW = '0;
        fillTable();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checkStatus(statusWord(0, 0, 1, 1), "after reset");

        // Odd rows write the load bit before any sample is pushed
        for (int r = 0; r < numRows; r++) begin
            runTransform(r, rowInverse[r] ? startIWord : startFWord, (r % 2) == 1);
        end

        runTransform(4, startFWord | startIWord, 1'b0);    // Both start bits at once

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/butterflyUnit.sv
`timescale 1ns/1ns
`default_nettype none

module butterflyUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  fftPkg::sample_t             a,
    input  fftPkg::sample_t             b,
    input  logic [fftPkg::addrBits-2:0] twIndex,
    input  logic                        inverse,
    output fftPkg::sample_t             x,
    output fftPkg::sample_t             y
);
    import fftPkg::*;

    logic signed [dataBits-1:0] wRe;
    logic signed [dataBits-1:0] wIm;
    logic signed [accBits-1:0]  tRe;
    logic signed [accBits-1:0]  tIm;
    logic signed [accBits-1:0]  sumRe;
    logic signed [accBits-1:0]  sumIm;
    logic signed [accBits-1:0]  difRe;
    logic signed [accBits-1:0]  difIm;

    always_comb begin
        wRe = twiddleRe[twIndex];
        wIm = inverse ? -twiddleIm[twIndex] : twiddleIm[twIndex];   // Conjugate for IFFT

        // t = b * W, truncated back to sample scale
        tRe = (b.re * wRe - b.im * wIm) >>> twBits;
        tIm = (b.re * wIm + b.im * wRe) >>> twBits;

        sumRe = a.re + tRe;
        sumIm = a.im + tIm;
        difRe = a.re - tRe;
        difIm = a.im - tIm;

        // Per-stage halving builds up the 1/N of the inverse
        if (inverse) begin
            sumRe = sumRe >>> 1;
            sumIm = sumIm >>> 1;
            difRe = difRe >>> 1;
            difIm = difIm >>> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else begin
            x.re <= sumRe[dataBits-1:0];
            x.im <= sumIm[dataBits-1:0];
            y.re <= difRe[dataBits-1:0];
            y.im <= difIm[dataBits-1:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/fftAccel.sv
`timescale 1ns/1ns
`default_nettype none

module fftAccel (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [4:2]  adr,
    input  logic [31:0] datW,
    output logic [31:0] datR,
    output logic        ack
);
    import fftPkg::*;

    logic    startF;
    logic    startI;
    logic    startLoadingRam;
    logic    transformComplete;
    logic    calculating;
    logic    aDone;
    logic    inPush;
    logic    inPop;
    logic    inFull;
    logic    inEmpty;
    logic    outPush;
    logic    outPop;
    logic    outEmpty;
    sample_t inWrData;
    sample_t inRdData;
    sample_t outWrData;
    sample_t outRdData;

    fftCtrlIf ctlIf ();

    wbRegs regs (
        .clk               (clk),
        .rst               (rst),
        .cyc               (cyc),
        .stb               (stb),
        .we                (we),
        .adr               (adr),
        .datW              (datW),
        .datR              (datR),
        .ack               (ack),
        .startF            (startF),
        .startI            (startI),
        .startLoadingRam   (startLoadingRam),
        .transformComplete (transformComplete),
        .calculating       (calculating),
        .aDone             (aDone),
        .inPush            (inPush),
        .inData            (inWrData),
        .inFull            (inFull),
        .inEmpty           (inEmpty),
        .outPop            (outPop),
        .outData           (outRdData),
        .outEmpty          (outEmpty)
    );

    fftCtrl ctrl (
        .clk               (clk),
        .rst               (rst),
        .startF            (startF),
        .startI            (startI),
        .startLoadingRam   (startLoadingRam),
        .transformComplete (transformComplete),
        .ctl               (ctlIf.ctrl),
        .calculating       (calculating),
        .aDone             (aDone)
    );

    fftCore core (
        .clk     (clk),
        .rst     (rst),
        .ctl     (ctlIf.core),
        .inData  (inRdData),
        .inEmpty (inEmpty),
        .inPop   (inPop),
        .outData (outWrData),
        .outPush (outPush)
    );

    sampleFifo inFifo (
        .clk    (clk),
        .rst    (rst),
        .push   (inPush),
        .pop    (inPop),
        .wrData (inWrData),
        .rdData (inRdData),
        .empty  (inEmpty),
        .full   (inFull)
    );

    // Holds a whole transform, so the unload never sees it full
    sampleFifo outFifo (
        .clk    (clk),
        .rst    (rst),
        .push   (outPush),
        .pop    (outPop),
        .wrData (outWrData),
        .rdData (outRdData),
        .empty  (outEmpty),
        .full   ()
    );

endmodule

`default_nettype wire

//--- verilog/fftCore.sv
`timescale 1ns/1ns
`default_nettype none

module fftCore (
    input  logic            clk,
    input  logic            rst,
    fftCtrlIf.core          ctl,
    input  fftPkg::sample_t inData,
    input  logic            inEmpty,
    output logic            inPop,
    output fftPkg::sample_t outData,
    output logic            outPush
);
    import fftPkg::*;

    sample_t             ram [fftPoints];
    logic [2:0]          lvl;
    logic [2:0]          prevLvl;
    logic                phaseStart;
    logic [addrBits:0]   cnt;            // Sample index, or butterfly index in compute
    logic [addrBits:0]   curCnt;
    logic [1:0]          beat;           // Read, butterfly, write
    logic [1:0]          curBeat;
    logic                lastBeat;
    logic [1:0]          stage;
    logic [addrBits-1:0] bIdx;
    logic [addrBits-1:0] half;
    logic [addrBits-1:0] pos;
    logic [addrBits-1:0] twFull;
    logic [addrBits-1:0] topAddr;
    logic [addrBits-1:0] botAddr;
    logic [addrBits-2:0] twIndex;
    sample_t             rdA;
    sample_t             rdB;
    sample_t             bfX;
    sample_t             bfY;

    function automatic logic [addrBits-1:0] bitRev(input logic [addrBits-1:0] k);
        logic [addrBits-1:0] r;
        for (int i = 0; i < addrBits; i++) begin
            r[i] = k[addrBits-1-i];
        end
        return r;
    endfunction

    // Counters read as zero in the first cycle of each phase
    assign lvl        = {ctl.loadOutBuffer, ctl.loadInternal, ctl.loadExternal};
    assign phaseStart = |(lvl & ~prevLvl);
    assign curCnt     = phaseStart ? '0 : cnt;
    assign curBeat    = phaseStart ? '0 : beat;
    assign lastBeat   = ctl.loadInternal && (curBeat == 2'd2);

    ////////////////////////////////////////////////////////////////////////////
    // Butterfly address generation
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        stage   = curCnt[3:2];
        bIdx    = {1'b0, curCnt[1:0]};
        half    = 3'(1) << stage;
        pos     = bIdx & (half - 1'b1);
        topAddr = ((bIdx >> stage) << (stage + 1)) | pos;
        botAddr = topAddr | half;
        twFull  = pos << (fftStages - 1 - stage);
        twIndex = twFull[addrBits-2:0];
    end

    assign inPop   = ctl.loadExternal && !inEmpty;     // Stalls while the FIFO is dry
    assign outPush = ctl.loadOutBuffer;
    assign outData = ram[curCnt[addrBits-1:0]];

    assign ctl.loadExternalDone = inPop && (int'(curCnt) == fftPoints - 1);
    assign ctl.done             = lastBeat && (int'(curCnt) == numBflies - 1);
    assign ctl.outFifoReady     = outPush && (int'(curCnt) == fftPoints - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prevLvl <= '0;
            cnt     <= '0;
            beat    <= '0;
        end else begin
            prevLvl <= lvl;
            cnt     <= curCnt;
            beat    <= curBeat;
            if (inPop || outPush) cnt <= curCnt + 1'b1;
            if (ctl.loadInternal) begin
                beat <= lastBeat ? 2'd0 : curBeat + 1'b1;
                if (lastBeat) cnt <= curCnt + 1'b1;
            end
        end
    end

    // Sample RAM and read pair
    always_ff @(posedge clk) begin
        if (inPop) ram[bitRev(curCnt[addrBits-1:0])] <= inData;
        if (ctl.loadInternal && curBeat == 2'd0) begin
            rdA <= ram[topAddr];
            rdB <= ram[botAddr];
        end
        if (lastBeat) begin             // In-place write back
            ram[topAddr] <= bfX;
            ram[botAddr] <= bfY;
        end
    end

    butterflyUnit bfly (
        .clk     (clk),
        .rst     (rst),
        .a       (rdA),
        .b       (rdB),
        .twIndex (twIndex),
        .inverse (ctl.isIFFT),
        .x       (bfX),
        .y       (bfY)
    );

endmodule

`default_nettype wire

//--- verilog/fftCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module fftCtrl (
    input  logic     clk,
    input  logic     rst,
    input  logic     startF,
    input  logic     startI,
    input  logic     startLoadingRam,
    input  logic     transformComplete,
    fftCtrlIf.ctrl   ctl,
    output logic     calculating,
    output logic     aDone
);
    import fftPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            aDone <= 1'b0;
        end else begin
            state <= nextState;
            aDone <= (nextState == DONE) && (state != DONE);   // First cycle of DONE
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state and phase levels
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState         = state;
        calculating       = (state != IDLE);
        ctl.loadExternal  = 1'b0;
        ctl.loadInternal  = 1'b0;
        ctl.isIFFT        = 1'b0;
        ctl.loadOutBuffer = 1'b0;

        case (state)
            IDLE: begin
                if (startF) begin
                    nextState = WAIT_LOAD_F;     // Forward wins if both are set
                end else if (startI) begin
                    nextState = WAIT_LOAD_I;
                end
            end

            // Host is still filling the input FIFO
            WAIT_LOAD_F: begin
                if (startLoadingRam) nextState = LOAD_F;
            end
            WAIT_LOAD_I: begin
                if (startLoadingRam) nextState = LOAD_I;
            end

            LOAD_F, LOAD_I: begin
                ctl.loadExternal = 1'b1;
                if (ctl.loadExternalDone) begin
                    nextState = (state == LOAD_F) ? CALC_F : CALC_I;
                end
            end

            CALC_F, CALC_I: begin
                ctl.loadInternal = 1'b1;
                ctl.isIFFT       = (state == CALC_I);
                if (ctl.done) nextState = UNLOAD;
            end

            UNLOAD: begin
                ctl.loadOutBuffer = 1'b1;
                if (ctl.outFifoReady) nextState = DONE;
            end

            DONE: begin
                if (transformComplete) nextState = IDLE;   // Host has drained results
            end

            default: nextState = IDLE;
        endcase
    end

    // Phases never overlap in the core
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctl.loadExternal, ctl.loadInternal, ctl.loadOutBuffer}));

    assert property (@(posedge clk) disable iff (rst)
        ctl.isIFFT |-> ctl.loadInternal);

endmodule

`default_nettype wire

//--- verilog/fftCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface fftCtrlIf;

    logic loadExternal;      // Fill RAM from input FIFO
    logic loadInternal;      // Run butterflies in place
    logic isIFFT;
    logic loadOutBuffer;     // Stream RAM into output FIFO

    // One-cycle end-of-phase pulses from the core
    logic loadExternalDone;
    logic done;
    logic outFifoReady;

    modport ctrl (
        output loadExternal, loadInternal, isIFFT, loadOutBuffer,
        input  loadExternalDone, done, outFifoReady
    );

    modport core (
        input  loadExternal, loadInternal, isIFFT, loadOutBuffer,
        output loadExternalDone, done, outFifoReady
    );

endinterface

`default_nettype wire

//--- verilog/fftPkg.sv
`default_nettype none

package fftPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Transform geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int fftPoints = 8;
    localparam int fftStages = 3;
    localparam int addrBits  = 3;
    localparam int dataBits  = 16;
    localparam int twBits    = 14;                      // Twiddle fraction bits
    localparam int accBits   = 2 * dataBits + 2;        // Complex product plus growth
    localparam int numBflies = fftStages * fftPoints / 2;
    localparam int fifoDepth = 8;

    typedef struct packed {
        logic signed [dataBits-1:0] re;
        logic signed [dataBits-1:0] im;
    } sample_t;

    // W8^k rounded to Q1.14
    localparam logic signed [dataBits-1:0] twiddleRe [fftPoints/2] =
        '{16'sd16384, 16'sd11585, 16'sd0, -16'sd11585};
    localparam logic signed [dataBits-1:0] twiddleIm [fftPoints/2] =
        '{16'sd0, -16'sd11585, -16'sd16384, -16'sd11585};

    typedef enum logic [3:0] {
        IDLE,
        WAIT_LOAD_F,
        WAIT_LOAD_I,
        LOAD_F,
        LOAD_I,
        CALC_F,
        CALC_I,
        UNLOAD,
        DONE
    } ctrlState_t;

    ////////////////////////////////////////////////////////////////////////////
    // Host register map
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        REG_CTRL     = 3'd0,
        REG_STATUS   = 3'd1,
        REG_DATA_IN  = 3'd2,
        REG_DATA_OUT = 3'd3,
        REG_ACK      = 3'd4
    } regAddr_t;

    // Control word bits
    localparam int ctrlStartF = 0;
    localparam int ctrlStartI = 1;
    localparam int ctrlLoad   = 2;

    // Status word bits
    localparam int statusBusy     = 0;
    localparam int statusDone     = 1;
    localparam int statusInEmpty  = 2;
    localparam int statusOutEmpty = 3;

endpackage

`default_nettype wire

//--- verilog/sampleFifo.sv
`timescale 1ns/1ns
`default_nettype none

module sampleFifo (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  logic            pop,
    input  fftPkg::sample_t wrData,
    output fftPkg::sample_t rdData,
    output logic            empty,
    output logic            full
);
    import fftPkg::*;

    sample_t                      mem [fifoDepth];
    logic [$clog2(fifoDepth)-1:0] wrPtr;
    logic [$clog2(fifoDepth)-1:0] rdPtr;
    logic [$clog2(fifoDepth):0]   count;
    logic                         doPush;
    logic                         doPop;

    assign doPush = push && !full;
    assign doPop  = pop && !empty;
    assign empty  = (count == 0);
    assign full   = (count == fifoDepth);
    assign rdData = mem[rdPtr];          // Head word visible without a pop

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;
            if (doPop) rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) mem[wrPtr] <= wrData;
    end

    // Producers and consumers are expected to respect the flags
    assert property (@(posedge clk) disable iff (rst) !(push && full));
    assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

`default_nettype wire

//--- verilog/wbRegs.sv
`timescale 1ns/1ns
`default_nettype none

module wbRegs (
    input  logic            clk,
    input  logic            rst,
    input  logic            cyc,
    input  logic            stb,
    input  logic            we,
    input  logic [2:0]      adr,
    input  logic [31:0]     datW,
    output logic [31:0]     datR,
    output logic            ack,
    output logic            startF,
    output logic            startI,
    output logic            startLoadingRam,
    output logic            transformComplete,
    input  logic            calculating,
    input  logic            aDone,
    output logic            inPush,
    output fftPkg::sample_t inData,
    input  logic            inFull,
    input  logic            inEmpty,
    output logic            outPop,
    input  fftPkg::sample_t outData,
    input  logic            outEmpty
);
    import fftPkg::*;

    regAddr_t    regSel;
    logic        stall;
    logic        accept;
    logic        wrAcc;
    logic        rdAcc;
    logic        doneFlag;
    logic [31:0] status;

    assign regSel = regAddr_t'(adr);
    assign stall  = we && (regSel == REG_DATA_IN) && inFull;   // Hold ack until room
    assign accept = cyc && stb && !ack && !stall;
    assign wrAcc  = accept && we;
    assign rdAcc  = accept && !we;

    assign inPush = wrAcc && (regSel == REG_DATA_IN);
    assign inData = sample_t'(datW);                           // re in upper half
    assign outPop = rdAcc && (regSel == REG_DATA_OUT) && !outEmpty;

    always_comb begin
        status                 = '0;
        status[statusBusy]     = calculating;
        status[statusDone]     = doneFlag;
        status[statusInEmpty]  = inEmpty;
        status[statusOutEmpty] = outEmpty;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack               <= 1'b0;
            datR              <= '0;
            startF            <= 1'b0;
            startI            <= 1'b0;
            startLoadingRam   <= 1'b0;
            transformComplete <= 1'b0;
            doneFlag          <= 1'b0;
        end else begin
            ack <= accept;

            // Register writes become single-cycle strobes
            startF            <= wrAcc && (regSel == REG_CTRL) && datW[ctrlStartF];
            startI            <= wrAcc && (regSel == REG_CTRL) && datW[ctrlStartI];
            startLoadingRam   <= wrAcc && (regSel == REG_CTRL) && datW[ctrlLoad];
            transformComplete <= wrAcc && (regSel == REG_ACK);

            if (aDone) begin
                doneFlag <= 1'b1;
            end else if (startF || startI) begin
                doneFlag <= 1'b0;
            end

            if (rdAcc) begin
                case (regSel)
                    REG_STATUS:   datR <= status;
                    REG_DATA_OUT: datR <= outEmpty ? '0 : outData;
                    default:      datR <= '0;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

`default_nettype wire
